//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } aluop_t;

  typedef enum logic [1:0] {
    PC_NPC,
    PC_BR,
    PC_JMP
  } pcsel_t;

  // All zero is a bubble
  typedef struct packed {
    aluop_t   aluop;
    logic     use_imm;
    logic     rf_wen;
    regbits_t wsel;
    logic     dren;
    logic     dwen;
    logic     halt;
    regbits_t rs;
    regbits_t rt;
  } ctrl_t;

endpackage

`default_nettype wire

//--- rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  typedef struct packed {
    logic          valid;
    isa_pkg::word_t instr;
    isa_pkg::word_t npc;
  } fd_t;

  typedef struct packed {
    isa_pkg::ctrl_t ctrl;
    isa_pkg::word_t rdat1;
    isa_pkg::word_t rdat2;
    isa_pkg::word_t imm32;
  } dx_t;

  typedef struct packed {
    isa_pkg::ctrl_t ctrl;
    isa_pkg::word_t aluout;
    isa_pkg::word_t store;
  } xm_t;

  typedef struct packed {
    isa_pkg::ctrl_t ctrl;
    isa_pkg::word_t wdat;
  } mw_t;

  typedef struct packed {
    logic           ren;
    logic           wen;
    isa_pkg::word_t addr;
    isa_pkg::word_t store;
  } dmem_req_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_t;

endpackage

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire logic              CLK,
  input  wire logic              nRST,
  input  wire logic              wen_i,
  input  isa_pkg::regbits_t      wsel_i,
  input  isa_pkg::word_t         wdat_i,
  input  isa_pkg::regbits_t      rsel1_i,
  input  isa_pkg::regbits_t      rsel2_i,
  output isa_pkg::word_t         rdat1_o,
  output isa_pkg::word_t         rdat2_o
);

  isa_pkg::word_t regs [31:1];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && wsel_i != '0) begin
      regs[wsel_i] <= wdat_i;
    end
  end

  // Same-cycle write shows through to decode
  always_comb begin
    if (rsel1_i == '0) rdat1_o = '0;
    else if (wen_i && wsel_i == rsel1_i) rdat1_o = wdat_i;
    else rdat1_o = regs[rsel1_i];
    if (rsel2_i == '0) rdat2_o = '0;
    else if (wen_i && wsel_i == rsel2_i) rdat2_o = wdat_i;
    else rdat2_o = regs[rsel2_i];
  end

  // Decode must never mark $zero as a destination
  assert property (@(posedge CLK) disable iff (!nRST) !(wen_i && wsel_i == '0))
    else $error("register zero written");

endmodule

`default_nettype wire

//--- rtl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  isa_pkg::word_t   instr_i,
  input  isa_pkg::word_t   npc_i,
  input  isa_pkg::word_t   rdat1_i,
  input  isa_pkg::word_t   rdat2_i,
  output isa_pkg::ctrl_t   ctrl_o,
  output isa_pkg::word_t   imm32_o,
  output isa_pkg::pcsel_t  pcsel_o,
  output isa_pkg::word_t   target_o
);

  isa_pkg::opcode_t op;
  isa_pkg::funct_t  fn;
  isa_pkg::word_t   simm;
  isa_pkg::word_t   zimm;
  logic             equal;

  assign op    = isa_pkg::opcode_t'(instr_i[31:26]);
  assign fn    = isa_pkg::funct_t'(instr_i[5:0]);
  assign simm  = {{16{instr_i[15]}}, instr_i[15:0]};
  assign zimm  = {16'h0000, instr_i[15:0]};
  assign equal = (rdat1_i == rdat2_i);

  always_comb begin
    ctrl_o   = '0;
    imm32_o  = simm;
    pcsel_o  = isa_pkg::PC_NPC;
    target_o = npc_i + (simm << 2);
    case (op)
      isa_pkg::RTYPE: begin
        ctrl_o.rs     = instr_i[25:21];
        ctrl_o.rt     = instr_i[20:16];
        ctrl_o.wsel   = instr_i[15:11];
        ctrl_o.rf_wen = 1'b1;
        case (fn)
          isa_pkg::ADDU: ctrl_o.aluop = isa_pkg::ALU_ADD;
          isa_pkg::SUBU: ctrl_o.aluop = isa_pkg::ALU_SUB;
          isa_pkg::AND:  ctrl_o.aluop = isa_pkg::ALU_AND;
          isa_pkg::OR:   ctrl_o.aluop = isa_pkg::ALU_OR;
          isa_pkg::SLT:  ctrl_o.aluop = isa_pkg::ALU_SLT;
          default:       ctrl_o = '0;
        endcase
      end
      isa_pkg::ADDIU, isa_pkg::ORI, isa_pkg::LUI, isa_pkg::LW: begin
        ctrl_o.rs      = (op == isa_pkg::LUI) ? '0 : instr_i[25:21];
        ctrl_o.wsel    = instr_i[20:16];
        ctrl_o.rf_wen  = 1'b1;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.dren    = (op == isa_pkg::LW);
        if (op == isa_pkg::ORI) ctrl_o.aluop = isa_pkg::ALU_OR;
        else if (op == isa_pkg::LUI) ctrl_o.aluop = isa_pkg::ALU_LUI;
        else ctrl_o.aluop = isa_pkg::ALU_ADD;
        if (op == isa_pkg::ORI || op == isa_pkg::LUI) imm32_o = zimm;
      end
      isa_pkg::SW: begin
        ctrl_o.rs      = instr_i[25:21];
        ctrl_o.rt      = instr_i[20:16];
        ctrl_o.use_imm = 1'b1;
        ctrl_o.dwen    = 1'b1;
        ctrl_o.aluop   = isa_pkg::ALU_ADD;
      end
      isa_pkg::BEQ, isa_pkg::BNE: begin
        ctrl_o.rs = instr_i[25:21];
        ctrl_o.rt = instr_i[20:16];
        if (equal == (op == isa_pkg::BEQ)) pcsel_o = isa_pkg::PC_BR;
      end
      isa_pkg::J: begin
        pcsel_o  = isa_pkg::PC_JMP;
        target_o = {npc_i[31:28], instr_i[25:0], 2'b00};
      end
      isa_pkg::HALT: ctrl_o.halt = 1'b1;
      default: ctrl_o = '0;
    endcase
    // Writes to $zero are dropped here
    if (ctrl_o.wsel == '0) ctrl_o.rf_wen = 1'b0;
  end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  pipe_pkg::dx_t   dx_i,
  input  isa_pkg::word_t  mem_fwd_i,
  input  isa_pkg::word_t  wb_fwd_i,
  input  pipe_pkg::fwd_t  fwd_a_i,
  input  pipe_pkg::fwd_t  fwd_b_i,
  output pipe_pkg::xm_t   xm_o
);

  isa_pkg::word_t opa;
  isa_pkg::word_t rt_val;
  isa_pkg::word_t opb;
  isa_pkg::word_t result;

  always_comb begin
    case (fwd_a_i)
      pipe_pkg::FWD_MEM: opa = mem_fwd_i;
      pipe_pkg::FWD_WB:  opa = wb_fwd_i;
      default:           opa = dx_i.rdat1;
    endcase
    case (fwd_b_i)
      pipe_pkg::FWD_MEM: rt_val = mem_fwd_i;
      pipe_pkg::FWD_WB:  rt_val = wb_fwd_i;
      default:           rt_val = dx_i.rdat2;
    endcase
  end

  assign opb = dx_i.ctrl.use_imm ? dx_i.imm32 : rt_val;

  always_comb begin
    case (dx_i.ctrl.aluop)
      isa_pkg::ALU_ADD: result = opa + opb;
      isa_pkg::ALU_SUB: result = opa - opb;
      isa_pkg::ALU_AND: result = opa & opb;
      isa_pkg::ALU_OR:  result = opa | opb;
      isa_pkg::ALU_SLT: result = {31'd0, $signed(opa) < $signed(opb)};
      isa_pkg::ALU_LUI: result = opb << 16;
      default:          result = '0;
    endcase
  end

  // Store data is the forwarded rt, never the immediate
  always_comb begin
    xm_o.ctrl   = dx_i.ctrl;
    xm_o.aluout = result;
    xm_o.store  = rt_val;
  end

endmodule

`default_nettype wire

//--- rtl/hazard_forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_forward_unit (
  input  isa_pkg::ctrl_t  id_ctrl_i,
  input  isa_pkg::ctrl_t  dx_ctrl_i,
  input  isa_pkg::ctrl_t  xm_ctrl_i,
  input  isa_pkg::ctrl_t  mw_ctrl_i,
  input  wire logic       id_branch_i,
  output pipe_pkg::fwd_t  fwd_a_o,
  output pipe_pkg::fwd_t  fwd_b_o,
  output logic            stall_o
);

  logic load_use;
  logic branch_wait;

  // Stage writes a nonzero register r
  function automatic logic writes(input isa_pkg::ctrl_t c, input isa_pkg::regbits_t r);
    writes = c.rf_wen && (c.wsel != '0) && (c.wsel == r);
  endfunction

  always_comb begin
    if (writes(xm_ctrl_i, dx_ctrl_i.rs)) fwd_a_o = pipe_pkg::FWD_MEM;
    else if (writes(mw_ctrl_i, dx_ctrl_i.rs)) fwd_a_o = pipe_pkg::FWD_WB;
    else fwd_a_o = pipe_pkg::FWD_NONE;
    if (writes(xm_ctrl_i, dx_ctrl_i.rt)) fwd_b_o = pipe_pkg::FWD_MEM;
    else if (writes(mw_ctrl_i, dx_ctrl_i.rt)) fwd_b_o = pipe_pkg::FWD_WB;
    else fwd_b_o = pipe_pkg::FWD_NONE;
  end

  assign load_use = dx_ctrl_i.dren &&
                    (writes(dx_ctrl_i, id_ctrl_i.rs) || writes(dx_ctrl_i, id_ctrl_i.rt));

  // Branch compares in decode, so values in flight must reach writeback first
  assign branch_wait = id_branch_i &&
                       (writes(dx_ctrl_i, id_ctrl_i.rs) || writes(dx_ctrl_i, id_ctrl_i.rt) ||
                        writes(xm_ctrl_i, id_ctrl_i.rs) || writes(xm_ctrl_i, id_ctrl_i.rt));

  assign stall_o = load_use || branch_wait;

  // Load data exists only from writeback on
  always_comb begin
    if (xm_ctrl_i.dren) begin
      assert (fwd_a_o != pipe_pkg::FWD_MEM && fwd_b_o != pipe_pkg::FWD_MEM)
        else $error("load in memory stage forwarded to execute");
    end
  end

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
  parameter isa_pkg::word_t PC_INIT = '0
) (
  input  wire logic           CLK,
  input  wire logic           nRST,
  output isa_pkg::word_t      imem_addr_o,
  input  isa_pkg::word_t      imem_load_i,
  input  wire logic           ihit_i,
  output pipe_pkg::dmem_req_t dmem_req_o,
  input  isa_pkg::word_t      dmem_load_i,
  input  wire logic           dhit_i,
  output logic                halt_o
);

  isa_pkg::word_t  pc;
  isa_pkg::word_t  npc;
  pipe_pkg::fd_t   fd;
  pipe_pkg::dx_t   dx;
  pipe_pkg::xm_t   xm;
  pipe_pkg::mw_t   mw;
  pipe_pkg::xm_t   xm_next;

  isa_pkg::ctrl_t  id_ctrl;
  isa_pkg::word_t  imm32;
  isa_pkg::pcsel_t pcsel;
  isa_pkg::word_t  target;
  isa_pkg::word_t  rdat1;
  isa_pkg::word_t  rdat2;
  pipe_pkg::fwd_t  fwd_a;
  pipe_pkg::fwd_t  fwd_b;
  logic            stall;
  logic            id_branch;
  logic            advance;
  logic            halt_seen;
  logic            fetch_stop;

  // Memory stage waits on dhit only when it holds an access
  assign advance = ihit_i && (!(xm.ctrl.dren || xm.ctrl.dwen) || dhit_i);

  assign npc         = pc + 32'd4;
  assign imem_addr_o = pc;

  assign id_branch = fd.valid && (fd.instr[31:26] == isa_pkg::BEQ ||
                                  fd.instr[31:26] == isa_pkg::BNE);

  // Nothing past HALT is fetched
  assign fetch_stop = halt_seen || id_ctrl.halt;

  register_file rf (
    .CLK     (CLK),
    .nRST    (nRST),
    .wen_i   (mw.ctrl.rf_wen && advance),
    .wsel_i  (mw.ctrl.wsel),
    .wdat_i  (mw.wdat),
    .rsel1_i (id_ctrl.rs),
    .rsel2_i (id_ctrl.rt),
    .rdat1_o (rdat1),
    .rdat2_o (rdat2)
  );

  decode_unit du (
    .instr_i  (fd.instr),
    .npc_i    (fd.npc),
    .rdat1_i  (rdat1),
    .rdat2_i  (rdat2),
    .ctrl_o   (id_ctrl),
    .imm32_o  (imm32),
    .pcsel_o  (pcsel),
    .target_o (target)
  );

  hazard_forward_unit hfu (
    .id_ctrl_i   (id_ctrl),
    .dx_ctrl_i   (dx.ctrl),
    .xm_ctrl_i   (xm.ctrl),
    .mw_ctrl_i   (mw.ctrl),
    .id_branch_i (id_branch),
    .fwd_a_o     (fwd_a),
    .fwd_b_o     (fwd_b),
    .stall_o     (stall)
  );

  execute_stage ex (
    .dx_i      (dx),
    .mem_fwd_i (xm.aluout),
    .wb_fwd_i  (mw.wdat),
    .fwd_a_i   (fwd_a),
    .fwd_b_i   (fwd_b),
    .xm_o      (xm_next)
  );

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc        <= PC_INIT;
      fd        <= '0;
      dx        <= '0;
      xm        <= '0;
      mw        <= '0;
      halt_seen <= 1'b0;
    end else if (advance) begin
      xm <= xm_next;
      mw <= '{ctrl: xm.ctrl, wdat: xm.ctrl.dren ? dmem_load_i : xm.aluout};
      if (stall) begin
        dx <= '0;
      end else begin
        dx <= '{ctrl: id_ctrl, rdat1: rdat1, rdat2: rdat2, imm32: imm32};
        if (id_ctrl.halt) halt_seen <= 1'b1;
        // Taken branch or jump squashes the fetched word
        if (fetch_stop || pcsel != isa_pkg::PC_NPC) begin
          fd <= '0;
        end else begin
          fd <= '{valid: 1'b1, instr: imem_load_i, npc: npc};
        end
        if (pcsel != isa_pkg::PC_NPC) pc <= target;
        else if (!fetch_stop) pc <= npc;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt_o <= 1'b0;
    end else begin
      halt_o <= halt_o | mw.ctrl.halt;
    end
  end

  assign dmem_req_o = '{ren: xm.ctrl.dren, wen: xm.ctrl.dwen,
                        addr: xm.aluout, store: xm.store};

  assert property (@(posedge CLK) disable iff (!nRST) !(dmem_req_o.ren && dmem_req_o.wen))
    else $error("data read and write requested together");

endmodule

`default_nettype wire

//--- verif/datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_tb;

  localparam int ROWS = 6;
  localparam int MAX_CYCLES = 2000;

  logic                CLK;
  logic                nRST;
  isa_pkg::word_t      imem_addr_o;
  isa_pkg::word_t      imem_load_i;
  logic                ihit_i;
  pipe_pkg::dmem_req_t dmem_req_o;
  isa_pkg::word_t      dmem_load_i;
  logic                dhit_i;
  logic                halt_o;

  // Test table
  string          test_name [ROWS];
  isa_pkg::word_t prog      [ROWS][12];
  int             prog_len  [ROWS];
  isa_pkg::word_t exp_addr  [ROWS][4];
  isa_pkg::word_t exp_data  [ROWS][4];
  int             exp_count [ROWS];
  bit             rand_w    [ROWS];
  isa_pkg::word_t pre_addr  [ROWS];
  isa_pkg::word_t pre_data  [ROWS];

  isa_pkg::word_t imem [0:15];
  isa_pkg::word_t dmem [0:63];
  isa_pkg::word_t rng;
  int             iwait;
  int             dwait;
  int             store_idx;
  int             value_errors;
  int             other_errors;

  datapath #(.PC_INIT(32'h0000_0000)) uut (
    .CLK         (CLK),
    .nRST        (nRST),
    .imem_addr_o (imem_addr_o),
    .imem_load_i (imem_load_i),
    .ihit_i      (ihit_i),
    .dmem_req_o  (dmem_req_o),
    .dmem_load_i (dmem_load_i),
    .dhit_i      (dhit_i),
    .halt_o      (halt_o)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic isa_pkg::word_t lcg_next(input isa_pkg::word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Background contents of data memory
  function automatic isa_pkg::word_t fill_word(input isa_pkg::word_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'hbeef_0000;
  endfunction

  function automatic isa_pkg::word_t enc_r(input isa_pkg::funct_t fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic isa_pkg::word_t enc_i(input isa_pkg::opcode_t op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic isa_pkg::word_t enc_j(input logic [25:0] word_idx);
    return {isa_pkg::J, word_idx};
  endfunction

  task automatic check_word(input string name, input isa_pkg::word_t exp,
                            input isa_pkg::word_t act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_halt(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic add_instr(input int r, input isa_pkg::word_t w);
    prog[r][prog_len[r]] = w;
    prog_len[r]++;
  endtask

  task automatic add_store(input int r, input isa_pkg::word_t a, input isa_pkg::word_t d);
    exp_addr[r][exp_count[r]] = a;
    exp_data[r][exp_count[r]] = d;
    exp_count[r]++;
  endtask

  task automatic build_table();
    isa_pkg::word_t halt_w;
    halt_w = {isa_pkg::HALT, 26'd0};
    for (int r = 0; r < ROWS; r++) begin
      prog_len[r]  = 0;
      exp_count[r] = 0;
      rand_w[r]    = 1'b0;
      pre_addr[r]  = 32'h0000_00fc;
      pre_data[r]  = fill_word(32'h0000_00fc);
      for (int i = 0; i < 12; i++) prog[r][i] = '0;
    end
    test_name[0] = "arith_fwd";
    add_instr(0, enc_i(isa_pkg::ADDIU, 5'd0, 5'd1, 16'd7));
    add_instr(0, enc_i(isa_pkg::ADDIU, 5'd0, 5'd2, 16'd5));
    add_instr(0, enc_r(isa_pkg::ADDU, 5'd1, 5'd2, 5'd3));
    add_instr(0, enc_r(isa_pkg::SUBU, 5'd3, 5'd1, 5'd4));
    add_instr(0, enc_r(isa_pkg::SLT, 5'd2, 5'd1, 5'd5));
    add_instr(0, enc_r(isa_pkg::SLT, 5'd1, 5'd2, 5'd6));
    add_instr(0, enc_i(isa_pkg::SW, 5'd0, 5'd3, 16'h0040));
    add_instr(0, enc_i(isa_pkg::SW, 5'd0, 5'd4, 16'h0044));
    add_instr(0, enc_i(isa_pkg::SW, 5'd0, 5'd5, 16'h0048));
    add_instr(0, enc_i(isa_pkg::SW, 5'd0, 5'd6, 16'h004c));
    add_instr(0, halt_w);
    add_store(0, 32'h40, 32'd12);
    add_store(0, 32'h44, 32'd5);
    add_store(0, 32'h48, 32'd1);
    add_store(0, 32'h4c, 32'd0);
    test_name[1] = "immediates";
    add_instr(1, enc_i(isa_pkg::ADDIU, 5'd0, 5'd1, 16'hfffd));
    add_instr(1, enc_i(isa_pkg::ORI, 5'd0, 5'd2, 16'h8001));
    add_instr(1, enc_i(isa_pkg::LUI, 5'd0, 5'd3, 16'h1234));
    add_instr(1, enc_r(isa_pkg::OR, 5'd3, 5'd2, 5'd4));
    for (int i = 1; i <= 4; i++) begin
      add_instr(1, enc_i(isa_pkg::SW, 5'd0, 5'(i), 16'(16'h003c + 4 * i)));
    end
    add_instr(1, halt_w);
    add_store(1, 32'h40, 32'hffff_fffd);
    add_store(1, 32'h44, 32'h0000_8001);
    add_store(1, 32'h48, 32'h1234_0000);
    add_store(1, 32'h4c, 32'h1234_8001);
    test_name[2] = "load_use";
    pre_addr[2] = 32'h80;
    pre_data[2] = 32'h0000_1234;
    add_instr(2, enc_i(isa_pkg::LW, 5'd0, 5'd1, 16'h0080));
    add_instr(2, enc_i(isa_pkg::ADDIU, 5'd1, 5'd2, 16'h0010));
    add_instr(2, enc_r(isa_pkg::AND, 5'd2, 5'd1, 5'd3));
    add_instr(2, enc_i(isa_pkg::SW, 5'd0, 5'd2, 16'h0040));
    add_instr(2, enc_i(isa_pkg::SW, 5'd0, 5'd3, 16'h0044));
    add_instr(2, enc_i(isa_pkg::LW, 5'd0, 5'd4, 16'h0084));
    add_instr(2, enc_i(isa_pkg::SW, 5'd0, 5'd4, 16'h0048));
    add_instr(2, halt_w);
    add_store(2, 32'h40, 32'h0000_1244);
    add_store(2, 32'h44, 32'h0000_1204);
    add_store(2, 32'h48, fill_word(32'h84));
    test_name[3] = "branches";
    add_instr(3, enc_i(isa_pkg::ADDIU, 5'd0, 5'd1, 16'd3));
    add_instr(3, enc_i(isa_pkg::ADDIU, 5'd0, 5'd2, 16'd3));
    add_instr(3, enc_i(isa_pkg::BEQ, 5'd1, 5'd2, 16'd2));
    add_instr(3, enc_i(isa_pkg::SW, 5'd0, 5'd1, 16'h0040));
    add_instr(3, enc_i(isa_pkg::SW, 5'd0, 5'd1, 16'h0044));
    add_instr(3, enc_i(isa_pkg::BNE, 5'd1, 5'd2, 16'd1));
    add_instr(3, enc_i(isa_pkg::SW, 5'd0, 5'd2, 16'h0048));
    add_instr(3, enc_j(26'd9));
    add_instr(3, enc_i(isa_pkg::SW, 5'd0, 5'd1, 16'h004c));
    add_instr(3, enc_i(isa_pkg::ADDIU, 5'd1, 5'd3, 16'h0020));
    add_instr(3, enc_i(isa_pkg::SW, 5'd0, 5'd3, 16'h004c));
    add_instr(3, halt_w);
    add_store(3, 32'h48, 32'd3);
    add_store(3, 32'h4c, 32'h23);
    test_name[4] = "wait_states";
    rand_w[4]   = 1'b1;
    pre_addr[4] = 32'h80;
    pre_data[4] = 32'h0000_0100;
    add_instr(4, enc_i(isa_pkg::LW, 5'd0, 5'd1, 16'h0080));
    add_instr(4, enc_i(isa_pkg::ADDIU, 5'd0, 5'd2, 16'h0055));
    add_instr(4, enc_r(isa_pkg::ADDU, 5'd1, 5'd2, 5'd3));
    add_instr(4, enc_r(isa_pkg::SUBU, 5'd3, 5'd2, 5'd4));
    add_instr(4, enc_i(isa_pkg::SW, 5'd0, 5'd3, 16'h0040));
    add_instr(4, enc_i(isa_pkg::BNE, 5'd4, 5'd1, 16'd1));
    add_instr(4, enc_i(isa_pkg::SW, 5'd0, 5'd4, 16'h0044));
    add_instr(4, enc_r(isa_pkg::SLT, 5'd2, 5'd3, 5'd5));
    add_instr(4, enc_i(isa_pkg::SW, 5'd0, 5'd5, 16'h0048));
    add_instr(4, halt_w);
    add_store(4, 32'h40, 32'h155);
    add_store(4, 32'h44, 32'h100);
    add_store(4, 32'h48, 32'd1);
    test_name[5] = "halt_stops";
    rand_w[5] = 1'b1;
    add_instr(5, enc_i(isa_pkg::ADDIU, 5'd0, 5'd1, 16'h0077));
    add_instr(5, enc_i(isa_pkg::SW, 5'd0, 5'd1, 16'h0040));
    add_instr(5, halt_w);
    add_instr(5, enc_i(isa_pkg::SW, 5'd0, 5'd1, 16'h0044));
    add_instr(5, enc_i(isa_pkg::SW, 5'd0, 5'd1, 16'h0048));
    add_store(5, 32'h40, 32'h77);
  endtask

  task automatic note_store(input int r, input isa_pkg::word_t a, input isa_pkg::word_t d);
    if (store_idx < exp_count[r]) begin
      check_word($sformatf("%s.addr%0d", test_name[r], store_idx), exp_addr[r][store_idx], a);
      check_word($sformatf("%s.data%0d", test_name[r], store_idx), exp_data[r][store_idx], d);
    end else begin
      $display("Test %s stored %h to %h beyond the %0d expected stores",
               test_name[r], d, a, exp_count[r]);
      other_errors++;
    end
    store_idx++;
  endtask

  // Drives both memories for the coming rising edge
  task automatic serve_memories(input int r);
    if (rand_w[r] && iwait > 0) begin
      ihit_i      = 1'b0;
      imem_load_i = '0;
      iwait--;
    end else begin
      ihit_i      = 1'b1;
      imem_load_i = imem[imem_addr_o[5:2]];
      if (rand_w[r]) begin
        rng   = lcg_next(rng);
        iwait = int'(rng[31:16]) % 3;
      end
    end
    if (!(dmem_req_o.ren || dmem_req_o.wen)) begin
      dhit_i      = 1'b0;
      dmem_load_i = '0;
    end else if (rand_w[r] && dwait > 0) begin
      dhit_i      = 1'b0;
      dmem_load_i = '0;
      dwait--;
    end else begin
      dhit_i      = 1'b1;
      dmem_load_i = dmem[dmem_req_o.addr[7:2]];
      if (rand_w[r]) begin
        rng   = lcg_next(rng);
        dwait = int'(rng[31:16]) % 3;
      end
      // A store retires only when the whole pipeline moves
      if (dmem_req_o.wen && ihit_i) begin
        dmem[dmem_req_o.addr[7:2]] = dmem_req_o.store;
        note_store(r, dmem_req_o.addr, dmem_req_o.store);
      end
    end
  endtask

  task automatic run_row(input int r);
    int cycles;
    @(negedge CLK);
    nRST        = 1'b0;
    ihit_i      = 1'b0;
    dhit_i      = 1'b0;
    imem_load_i = '0;
    dmem_load_i = '0;
    for (int i = 0; i < 16; i++) imem[i] = (i < 12) ? prog[r][i] : '0;
    for (int i = 0; i < 64; i++) dmem[i] = fill_word(isa_pkg::word_t'(i * 4));
    dmem[pre_addr[r][7:2]] = pre_data[r];
    store_idx = 0;
    iwait     = 0;
    dwait     = 0;
    repeat (10) @(negedge CLK);
    nRST = 1'b1;
    check_halt({test_name[r], ".reset"}, 1'b0, halt_o);
    serve_memories(r);
    cycles = 0;
    while (!halt_o && cycles < MAX_CYCLES) begin
      @(negedge CLK);
      cycles++;
      serve_memories(r);
    end
    if (!halt_o) begin
      $display("Test %s timed out before halt_o rose", test_name[r]);
      other_errors++;
    end else begin
      // Halt must hold and nothing may store afterwards
      for (int k = 0; k < 6; k++) begin
        @(negedge CLK);
        serve_memories(r);
        check_halt({test_name[r], ".hold"}, 1'b1, halt_o);
      end
    end
    if (store_idx < exp_count[r]) begin
      $display("Test %s made only %0d of %0d expected stores",
               test_name[r], store_idx, exp_count[r]);
      other_errors++;
    end
  endtask

  initial begin
    nRST         = 1'b0;
    ihit_i       = 1'b0;
    dhit_i       = 1'b0;
    imem_load_i  = '0;
    dmem_load_i  = '0;
    value_errors = 0;
    other_errors = 0;
    rng          = 32'hdaa0_65c3;
    build_table();
    for (int r = 0; r < ROWS; r++) begin
      run_row(r);
    end
    $display("Value errors %0d, other errors %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/register_file.sv
rtl/decode_unit.sv
rtl/execute_stage.sv
rtl/hazard_forward_unit.sv
rtl/datapath.sv
verif/datapath_tb.sv

//--- Makefile
SRCS := $(wildcard rtl/*.sv) verif/datapath_tb.sv

.PHONY: run clean

run: obj_dir/Vdatapath_tb
	./obj_dir/Vdatapath_tb | tee sim.log
	grep -qx "NO ERRORS" sim.log

obj_dir/Vdatapath_tb: $(SRCS) verilog.f
	verilator --binary --timing --assert -f verilog.f --top-module datapath_tb -o Vdatapath_tb

clean:
	rm -rf obj_dir sim.log
